// ==== source/dram_cfg_pkg.sv ====
package dram_cfg_pkg;

  //////////////////////////////
  // Address and data widths
  //////////////////////////////

  parameter int BANK_W = 3;
  parameter int ROW_W  = 14;
  parameter int COL_W  = 10;
  parameter int DATA_W = 32;

  //////////////////////////////
  // Reset and timing defaults
  //////////////////////////////

  // Cycles the controller reset is held after the clock settles.
  parameter int RST_STAGES_DEF = 8;

  // Command spacing in dram_clk_0 cycles.
  parameter int T_RCD_DEF = 3;
  parameter int T_WR_DEF  = 4;
  parameter int T_RP_DEF  = 3;
  parameter int T_RFC_DEF = 20;

  parameter int REFRESH_INTERVAL_DEF = 200;

  parameter int QUEUE_DEPTH_DEF = 8;

endpackage

// ==== source/dram_cmd_pkg.sv ====
package dram_cmd_pkg;

  //////////////////////////////
  // Command opcodes
  //////////////////////////////

  typedef enum logic [2:0] {
    OP_NOP = 3'd0,
    OP_ACT = 3'd1,
    OP_RD  = 3'd2,
    OP_WR  = 3'd3,
    OP_PRE = 3'd4,
    OP_REF = 3'd5
  } dram_op_e;

  //////////////////////////////
  // User request, 60 bits
  //////////////////////////////

  typedef struct packed {
    logic                            is_write;
    logic [dram_cfg_pkg::BANK_W-1:0] bank;
    logic [dram_cfg_pkg::ROW_W-1:0]  row;
    logic [dram_cfg_pkg::COL_W-1:0]  col;
    logic [dram_cfg_pkg::DATA_W-1:0] wdata;
  } dram_req_t;

  //////////////////////////////
  // DRAM command, 62 bits
  //////////////////////////////

  // Row on ACT, col and wdata on RD/WR, bank on all but REF.
  typedef struct packed {
    dram_op_e                        op;
    logic [dram_cfg_pkg::BANK_W-1:0] bank;
    logic [dram_cfg_pkg::ROW_W-1:0]  row;
    logic [dram_cfg_pkg::COL_W-1:0]  col;
    logic [dram_cfg_pkg::DATA_W-1:0] wdata;
  } dram_cmd_t;

endpackage

// ==== source/dram_rst_seq.sv ====
module dram_rst_seq #(
  parameter int RST_STAGES = dram_cfg_pkg::RST_STAGES_DEF
) (
  input  logic dram_clk_0,
  input  logic reset_int,
  input  logic pll_locked,
  output logic dram_rst
);

  logic [RST_STAGES-1:0] rst_sr;
  logic                  rst_cond;

  // External reset or lost lock both restart the stretch.
  assign rst_cond = reset_int || !pll_locked;

  always_ff @(posedge dram_clk_0) begin
    if (rst_cond) begin
      rst_sr <= '1;
    end else begin
      rst_sr <= rst_sr << 1;
    end
  end

  // Last stage releases RST_STAGES cycles after the condition clears.
  assign dram_rst = rst_sr[RST_STAGES-1];

endmodule

// ==== source/refresh_timer.sv ====
module refresh_timer #(
  parameter int REFRESH_INTERVAL = dram_cfg_pkg::REFRESH_INTERVAL_DEF
) (
  input  logic dram_clk_0,
  input  logic dram_rst,
  input  logic refresh_ack,
  output logic refresh_pending
);

  localparam int CNT_W = (REFRESH_INTERVAL > 1) ? $clog2(REFRESH_INTERVAL) : 1;

  logic [CNT_W-1:0] interval_cnt;
  logic             interval_done;

  assign interval_done = (interval_cnt == CNT_W'(REFRESH_INTERVAL - 1));

  //////////////////////////////
  // Interval counter
  //////////////////////////////

  always_ff @(posedge dram_clk_0) begin
    if (dram_rst) begin
      interval_cnt <= '0;
    end else if (interval_done) begin
      interval_cnt <= '0;
    end else begin
      interval_cnt <= interval_cnt + 1'b1;
    end
  end

  //////////////////////////////
  // Pending flag
  //////////////////////////////

  // A wrap while already pending just keeps the flag set.
  always_ff @(posedge dram_clk_0) begin
    if (dram_rst) begin
      refresh_pending <= 1'b0;
    end else if (interval_done) begin
      refresh_pending <= 1'b1;
    end else if (refresh_ack) begin
      refresh_pending <= 1'b0;
    end
  end

endmodule

// ==== source/request_queue.sv ====
module request_queue #(
  parameter int DEPTH = dram_cfg_pkg::QUEUE_DEPTH_DEF
) (
  input  logic                    dram_clk_0,
  input  logic                    dram_rst,
  input  logic                    req_valid,
  input  dram_cmd_pkg::dram_req_t req,
  input  logic                    queue_pop,
  output dram_cmd_pkg::dram_req_t queue_head,
  output logic                    queue_empty,
  output logic                    overflow
);

  import dram_cmd_pkg::*;

  localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_W = $clog2(DEPTH + 1);

  dram_req_t          mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [COUNT_W-1:0] count;
  logic               full;
  logic               do_push;
  logic               do_pop;

  assign full        = (count == COUNT_W'(DEPTH));
  assign queue_empty = (count == '0);

  // A pop in the same cycle frees the slot for the push.
  assign do_pop  = queue_pop && !queue_empty;
  assign do_push = req_valid && (!full || do_pop);

  assign queue_head = mem[rd_ptr];

  //////////////////////////////
  // Storage
  //////////////////////////////

  always_ff @(posedge dram_clk_0) begin
    if (do_push) begin
      mem[wr_ptr] <= req;
    end
  end

  //////////////////////////////
  // Pointers and occupancy
  //////////////////////////////

  always_ff @(posedge dram_clk_0) begin
    if (dram_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Sticky until the next controller reset.
  always_ff @(posedge dram_clk_0) begin
    if (dram_rst) begin
      overflow <= 1'b0;
    end else if (req_valid && !do_push) begin
      overflow <= 1'b1;
    end
  end

endmodule

// ==== source/command_scheduler.sv ====
module command_scheduler #(
  parameter int T_RCD = dram_cfg_pkg::T_RCD_DEF,
  parameter int T_WR  = dram_cfg_pkg::T_WR_DEF,
  parameter int T_RP  = dram_cfg_pkg::T_RP_DEF,
  parameter int T_RFC = dram_cfg_pkg::T_RFC_DEF
) (
  input  logic                    dram_clk_0,
  input  logic                    dram_rst,
  input  logic                    refresh_pending,
  input  logic                    queue_empty,
  input  dram_cmd_pkg::dram_req_t queue_head,
  output logic                    refresh_ack,
  output logic                    queue_pop,
  output logic                    cmd_valid,
  output dram_cmd_pkg::dram_cmd_t cmd
);

  import dram_cmd_pkg::*;

  localparam int T_MAX_A = (T_RCD > T_WR) ? T_RCD : T_WR;
  localparam int T_MAX_B = (T_RP > T_RFC) ? T_RP : T_RFC;
  localparam int T_MAX   = (T_MAX_A > T_MAX_B) ? T_MAX_A : T_MAX_B;
  localparam int CNT_W   = $clog2(T_MAX + 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RCD,
    ST_WR,
    ST_RP,
    ST_RFC
  } state_t;

  state_t           state;
  logic [CNT_W-1:0] wait_cnt;
  dram_req_t        req_q;
  dram_cmd_t        cmd_next;
  logic             ready;
  logic             issue_ref;
  logic             issue_act;
  logic             issue_col;
  logic             issue_pre;

  //////////////////////////////
  // Issue decisions
  //////////////////////////////

  // Last cycle of tRP or tRFC doubles as the idle decision point.
  assign ready = (state == ST_IDLE) ||
                 (((state == ST_RP) || (state == ST_RFC)) && (wait_cnt == '0));

  // Refresh wins only here, never during an access.
  assign issue_ref = ready && refresh_pending;
  assign issue_act = ready && !refresh_pending && !queue_empty;
  assign issue_col = (state == ST_RCD) && (wait_cnt == '0);
  assign issue_pre = (state == ST_WR) && (wait_cnt == '0);

  always_comb begin
    cmd_next.op    = OP_NOP;
    cmd_next.bank  = req_q.bank;
    cmd_next.row   = req_q.row;
    cmd_next.col   = req_q.col;
    cmd_next.wdata = req_q.wdata;
    if (issue_ref) begin
      cmd_next.op = OP_REF;
    end else if (issue_act) begin
      cmd_next.op    = OP_ACT;
      cmd_next.bank  = queue_head.bank;
      cmd_next.row   = queue_head.row;
      cmd_next.col   = queue_head.col;
      cmd_next.wdata = queue_head.wdata;
    end else if (issue_col) begin
      cmd_next.op = req_q.is_write ? OP_WR : OP_RD;
    end else if (issue_pre) begin
      cmd_next.op = OP_PRE;
    end
  end

  //////////////////////////////
  // FSM and strobes
  //////////////////////////////

  always_ff @(posedge dram_clk_0) begin
    if (dram_rst) begin
      state       <= ST_IDLE;
      wait_cnt    <= '0;
      cmd_valid   <= 1'b0;
      refresh_ack <= 1'b0;
      queue_pop   <= 1'b0;
    end else begin
      cmd_valid   <= issue_ref || issue_act || issue_col || issue_pre;
      refresh_ack <= issue_ref;
      queue_pop   <= issue_act;
      if (issue_ref) begin
        state    <= ST_RFC;
        wait_cnt <= CNT_W'(T_RFC - 1);
      end else if (issue_act) begin
        state    <= ST_RCD;
        wait_cnt <= CNT_W'(T_RCD - 1);
      end else if (issue_col) begin
        state    <= ST_WR;
        wait_cnt <= CNT_W'(T_WR - 1);
      end else if (issue_pre) begin
        state    <= ST_RP;
        wait_cnt <= CNT_W'(T_RP - 1);
      end else if (ready) begin
        state <= ST_IDLE;
      end else begin
        wait_cnt <= wait_cnt - 1'b1;
      end
    end
  end

  // Request held from ACT through PRE.
  always_ff @(posedge dram_clk_0) begin
    cmd <= cmd_next;
    if (issue_act) begin
      req_q <= queue_head;
    end
  end

endmodule

// ==== source/dram_ctrl_top.sv ====
module dram_ctrl_top #(
  parameter int RST_STAGES       = dram_cfg_pkg::RST_STAGES_DEF,
  parameter int REFRESH_INTERVAL = dram_cfg_pkg::REFRESH_INTERVAL_DEF,
  parameter int QUEUE_DEPTH      = dram_cfg_pkg::QUEUE_DEPTH_DEF,
  parameter int T_RCD            = dram_cfg_pkg::T_RCD_DEF,
  parameter int T_WR             = dram_cfg_pkg::T_WR_DEF,
  parameter int T_RP             = dram_cfg_pkg::T_RP_DEF,
  parameter int T_RFC            = dram_cfg_pkg::T_RFC_DEF
) (
  input  logic                    dram_clk_0,
  input  logic                    reset_int,
  input  logic                    pll_locked,
  input  logic                    req_valid,
  input  dram_cmd_pkg::dram_req_t req,
  output logic                    cmd_valid,
  output dram_cmd_pkg::dram_cmd_t cmd,
  output logic                    overflow
);

  import dram_cmd_pkg::*;

  logic      dram_rst;
  logic      refresh_pending;
  logic      refresh_ack;
  logic      queue_empty;
  logic      queue_pop;
  dram_req_t queue_head;

  dram_rst_seq #(
    .RST_STAGES(RST_STAGES)
  ) dram_rst_seq_i (
    .dram_clk_0(dram_clk_0),
    .reset_int (reset_int),
    .pll_locked(pll_locked),
    .dram_rst  (dram_rst)
  );

  refresh_timer #(
    .REFRESH_INTERVAL(REFRESH_INTERVAL)
  ) refresh_timer_i (
    .dram_clk_0     (dram_clk_0),
    .dram_rst       (dram_rst),
    .refresh_ack    (refresh_ack),
    .refresh_pending(refresh_pending)
  );

  request_queue #(
    .DEPTH(QUEUE_DEPTH)
  ) request_queue_i (
    .dram_clk_0 (dram_clk_0),
    .dram_rst   (dram_rst),
    .req_valid  (req_valid),
    .req        (req),
    .queue_pop  (queue_pop),
    .queue_head (queue_head),
    .queue_empty(queue_empty),
    .overflow   (overflow)
  );

  command_scheduler #(
    .T_RCD(T_RCD),
    .T_WR (T_WR),
    .T_RP (T_RP),
    .T_RFC(T_RFC)
  ) command_scheduler_i (
    .dram_clk_0     (dram_clk_0),
    .dram_rst       (dram_rst),
    .refresh_pending(refresh_pending),
    .queue_empty    (queue_empty),
    .queue_head     (queue_head),
    .refresh_ack    (refresh_ack),
    .queue_pop      (queue_pop),
    .cmd_valid      (cmd_valid),
    .cmd            (cmd)
  );

endmodule

// ==== tests/dram_ctrl_props.sv ====
module dram_ctrl_props #(
  parameter int T_RCD = dram_cfg_pkg::T_RCD_DEF,
  parameter int T_WR  = dram_cfg_pkg::T_WR_DEF
) (
  input logic                    dram_clk_0,
  input logic                    dram_rst,
  input logic                    cmd_valid,
  input logic                    refresh_ack,
  input logic                    queue_pop,
  input logic                    issue_ref,
  input logic                    issue_act,
  input logic                    issue_col,
  input logic                    issue_pre,
  input dram_cmd_pkg::dram_cmd_t cmd
);

  timeunit 1ns;
  timeprecision 100ps;

  import dram_cmd_pkg::*;

  // Strobes stay quiet through reset and the cycle after.
  a_no_strobe_in_reset: assert property (@(posedge dram_clk_0)
    dram_rst |=> !cmd_valid && !refresh_ack && !queue_pop)
    else $error("strobe during controller reset");

  a_rcd_spacing: assert property (@(posedge dram_clk_0) disable iff (dram_rst)
    cmd_valid && cmd.op == OP_ACT |->
      ##T_RCD cmd_valid && (cmd.op == OP_RD || cmd.op == OP_WR))
    else $error("column command not T_RCD after ACT");

  a_wr_spacing: assert property (@(posedge dram_clk_0) disable iff (dram_rst)
    cmd_valid && (cmd.op == OP_RD || cmd.op == OP_WR) |-> ##T_WR cmd_valid && cmd.op == OP_PRE)
    else $error("PRE not T_WR after column command");

  // Never two issue decisions in one cycle.
  a_one_cmd: assert property (@(posedge dram_clk_0) disable iff (dram_rst)
    $onehot0({issue_ref, issue_act, issue_col, issue_pre}))
    else $error("more than one command issued in a cycle");

endmodule

bind command_scheduler dram_ctrl_props #(.T_RCD(T_RCD), .T_WR(T_WR)) dram_ctrl_props_i (
  .dram_clk_0(dram_clk_0), .dram_rst(dram_rst), .cmd_valid(cmd_valid),
  .refresh_ack(refresh_ack), .queue_pop(queue_pop),
  .issue_ref(issue_ref), .issue_act(issue_act), .issue_col(issue_col),
  .issue_pre(issue_pre), .cmd(cmd)
);

// ==== tests/dram_ctrl_tb.sv ====
module dram_ctrl_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import dram_cfg_pkg::*;
  import dram_cmd_pkg::*;

  localparam int REF_INT  = 200;
  localparam int T_ACCESS = T_RCD_DEF + T_WR_DEF + T_RP_DEF;
  localparam int WATCHDOG_CYCLES = 16 + 4 * REF_INT + 2 * RST_STAGES_DEF
                                   + 25 * (T_ACCESS + T_RFC_DEF) + 200;

  logic      dram_clk_0;
  logic      reset_int;
  logic      pll_locked;
  logic      req_valid;
  dram_req_t req;
  logic      cmd_valid;
  dram_cmd_t cmd;
  logic      overflow;

  int        cyc = 0;
  int        errors = 0;
  int        tests = 0;
  int        e_start;
  dram_cmd_t log_cmd[$];
  int        log_cyc[$];
  dram_req_t exp_q[$];

  dram_ctrl_top #(.RST_STAGES(RST_STAGES_DEF), .REFRESH_INTERVAL(REF_INT),
    .QUEUE_DEPTH(QUEUE_DEPTH_DEF), .T_RCD(T_RCD_DEF), .T_WR(T_WR_DEF),
    .T_RP(T_RP_DEF), .T_RFC(T_RFC_DEF)
  ) dram_ctrl_top_i (.*);

  always #10 dram_clk_0 = ~dram_clk_0;

  always @(posedge dram_clk_0) cyc <= cyc + 1;

  // Command monitor with cycle stamps.
  always @(negedge dram_clk_0) begin
    if (cmd_valid === 1'b1) begin
      log_cmd.push_back(cmd);
      log_cyc.push_back(cyc);
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * 20);
    $display("Run timed out before all tests finished");
    $display("TEST FAILED");
    $finish;
  end

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string msg);
    if (actual !== expected) begin
      $display("ERR t=%0t: %s, got %0h, expected %0h", $time, msg, actual, expected);
      errors++;
    end
  endtask

  function automatic dram_req_t random_req();
    dram_req_t r;
    r.is_write = 1'($urandom());
    r.bank     = BANK_W'($urandom());
    r.row      = ROW_W'($urandom());
    r.col      = COL_W'($urandom());
    r.wdata    = DATA_W'($urandom());
    return r;
  endfunction

  task automatic start_test();
    repeat (T_ACCESS + 2) @(posedge dram_clk_0);
    log_cmd.delete();
    log_cyc.delete();
    exp_q.delete();
    e_start = errors;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("%s finished with %0d errors", name, errors - e_start);
  endtask

  // Pushes every entry of exp_q in consecutive cycles.
  task automatic drive_reqs();
    foreach (exp_q[i]) begin
      @(posedge dram_clk_0);
      req_valid <= 1'b1;
      req       <= exp_q[i];
    end
    @(posedge dram_clk_0);
    req_valid <= 1'b0;
  endtask

  task automatic wait_op(input dram_op_e op, input int nth, input int max_cycles,
                         output int stamp);
    int seen;
    stamp = -1;
    for (int n = 0; n < max_cycles && stamp < 0; n++) begin
      @(posedge dram_clk_0);
      seen = 0;
      foreach (log_cmd[i]) begin
        if (log_cmd[i].op == op) begin
          seen++;
          if (seen == nth && stamp < 0) stamp = log_cyc[i];
        end
      end
    end
    if (stamp < 0) begin
      $display("Timed out waiting for command %s number %0d", op.name(), nth);
      errors++;
    end
  endtask

  // Walks the log against exp_q, skipping refreshes.
  task automatic check_accesses();
    int j;
    int act_cyc;
    int prev_act;
    dram_req_t r;
    j = 0;
    prev_act = -T_ACCESS;
    foreach (exp_q[k]) begin
      r = exp_q[k];
      while (j < log_cmd.size() && log_cmd[j].op == OP_REF) j++;
      if (j + 2 >= log_cmd.size()) begin
        $display("Commands missing for request %0d", k);
        errors++;
        return;
      end
      act_cyc = log_cyc[j];
      check_value(64'(log_cmd[j].op), 64'(OP_ACT), "ACT opcode");
      check_value(64'(log_cmd[j].bank), 64'(r.bank), "ACT bank");
      check_value(64'(log_cmd[j].row), 64'(r.row), "ACT row");
      check_value(64'(act_cyc - prev_act >= T_ACCESS), 64'(1), "ACT to ACT spacing");
      check_value(64'(log_cmd[j+1].op), r.is_write ? 64'(OP_WR) : 64'(OP_RD), "column opcode");
      check_value(64'(log_cyc[j+1]), 64'(act_cyc + T_RCD_DEF), "column command cycle");
      check_value(64'(log_cmd[j+1].bank), 64'(r.bank), "column bank");
      check_value(64'(log_cmd[j+1].col), 64'(r.col), "column address");
      if (r.is_write) check_value(64'(log_cmd[j+1].wdata), 64'(r.wdata), "write data");
      check_value(64'(log_cmd[j+2].op), 64'(OP_PRE), "PRE opcode");
      check_value(64'(log_cyc[j+2]), 64'(act_cyc + T_RCD_DEF + T_WR_DEF), "PRE cycle");
      check_value(64'(log_cmd[j+2].bank), 64'(r.bank), "PRE bank");
      prev_act = act_cyc;
      j += 3;
    end
  endtask

  task automatic check_reset_release(input int rel);
    int stamp;
    repeat (RST_STAGES_DEF + 1) begin
      check_value(64'(cmd_valid), 64'(0), "cmd_valid during reset stretch");
      check_value(64'(overflow), 64'(0), "overflow during reset stretch");
      @(negedge dram_clk_0);
    end
    wait_op(OP_REF, 1, REF_INT + RST_STAGES_DEF + 20, stamp);
    check_value(64'(stamp), 64'(rel + RST_STAGES_DEF + REF_INT + 1), "first REF cycle");
  endtask

  task automatic test_reset();
    int rel;
    e_start = errors;
    repeat (16) @(posedge dram_clk_0);
    reset_int <= 1'b0;
    @(negedge dram_clk_0);
    rel = cyc;
    check_reset_release(rel);
    // Lock loss restarts the stretch and the refresh count.
    // The request queued as lock drops is flushed and never served.
    @(posedge dram_clk_0);
    pll_locked <= 1'b0;
    req_valid  <= 1'b1;
    req        <= random_req();
    @(posedge dram_clk_0);
    req_valid <= 1'b0;
    repeat (2) @(posedge dram_clk_0);
    pll_locked <= 1'b1;
    log_cmd.delete();
    log_cyc.delete();
    @(negedge dram_clk_0);
    rel = cyc;
    check_reset_release(rel);
    check_value(64'(log_cmd.size()), 64'(1), "commands after lock loss");
    finish_test("reset");
  endtask

  task automatic test_single_write();
    int stamp;
    start_test();
    exp_q.push_back(random_req());
    exp_q[0].is_write = 1'b1;
    drive_reqs();
    wait_op(OP_PRE, 1, T_ACCESS + T_RFC_DEF + 20, stamp);
    check_accesses();
    finish_test("single_write");
  endtask

  task automatic test_burst();
    int stamp;
    start_test();
    repeat (5) exp_q.push_back(random_req());
    drive_reqs();
    wait_op(OP_PRE, 5, 5 * T_ACCESS + T_RFC_DEF + 30, stamp);
    check_accesses();
    finish_test("burst");
  endtask

  task automatic test_refresh();
    int r0;
    int r1;
    int act;
    start_test();
    wait_op(OP_REF, 1, REF_INT + 10, r0);
    // Request reaches the queue head as the refresh turns pending.
    while (cyc < r0 + REF_INT - 3) begin
      @(negedge dram_clk_0);
    end
    exp_q.push_back(random_req());
    drive_reqs();
    wait_op(OP_PRE, 1, T_ACCESS + T_RFC_DEF + 20, act);
    wait_op(OP_REF, 2, 5, r1);
    wait_op(OP_ACT, 1, 5, act);
    check_value(64'(r1), 64'(r0 + REF_INT), "REF interval");
    check_value(64'(act), 64'(r1 + T_RFC_DEF), "ACT behind refresh");
    foreach (log_cmd[i]) begin
      if (log_cmd[i].op == OP_REF && i + 1 < log_cmd.size())
        check_value(64'(log_cyc[i+1] - log_cyc[i] >= T_RFC_DEF), 64'(1), "gap after REF");
    end
    check_accesses();
    finish_test("refresh");
  endtask

  task automatic test_overflow();
    int stamp;
    start_test();
    check_value(64'(overflow), 64'(0), "overflow before test");
    repeat (QUEUE_DEPTH_DEF + 2) exp_q.push_back(random_req());
    drive_reqs();
    // One pop lands during the burst, so only the last push is dropped.
    void'(exp_q.pop_back());
    @(negedge dram_clk_0);
    check_value(64'(overflow), 64'(1), "overflow after full push");
    wait_op(OP_PRE, QUEUE_DEPTH_DEF + 1, (QUEUE_DEPTH_DEF + 2) * T_ACCESS + T_RFC_DEF, stamp);
    check_accesses();
    finish_test("overflow");
  endtask

  initial begin
    dram_clk_0 = 1'b0;
    reset_int  = 1'b1;
    pll_locked = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    void'($urandom(69185));
    test_reset();
    test_single_write();
    test_burst();
    test_refresh();
    test_overflow();
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
source/dram_cfg_pkg.sv
source/dram_cmd_pkg.sv
source/dram_rst_seq.sv
source/refresh_timer.sv
source/request_queue.sv
source/command_scheduler.sv
source/dram_ctrl_top.sv
tests/dram_ctrl_props.sv
tests/dram_ctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dram_ctrl_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
